// File: Makefile
TOP := coreInterruptTests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: project.f
rtl/corePkg.sv
rtl/phaseSequencer.sv
rtl/instructionDecoder.sv
rtl/registerDatapath.sv
rtl/interruptController.sv
rtl/programCounter.sv
rtl/core.sv
testbench/core_checker.sv
testbench/coreInterruptTests.sv

// File: testbench/coreInterruptTests.sv
`timescale 1ns/100ps

module coreInterruptTests
	import corePkg::*;
();

	localparam int numCycles = 2400;
	localparam int holdLimit = 64;
	localparam addrT mainAddr = 16'h0010;
	localparam addrT bodyAddr = 16'h0050;
	localparam addrT handler0Addr = 16'h01F0;
	localparam addrT handler1Addr = 16'h01F8;
	localparam addrT checkpointAddr = 16'h0200;

	logic clk;
	logic rst;
	logic int0;
	logic int1;
	wordT din;
	addrT addr;
	wordT dout;
	logic rdn;
	logic wrn;

	wordT mem [256];
	logic [15:0] lfsr;
	int wp;

	// ISA model state
	wordT regs [16];
	addrT modelPc;
	addrT modelRet;
	logic modelEn;
	logic modelInSvc;
	logic [1:0] seen0;
	logic [1:0] seen1;
	logic [3:0] irGroup;
	logic [3:0] irOp;
	regIdxT irDst;
	regIdxT irSrc;

	logic ack0;
	logic ack1;
	int hold0;
	int hold1;
	int errors;
	int checks;
	int taken0;
	int taken1;

	core #(
		.numRegs (16)
	) i_dut (
		.clk  (clk),
		.rst  (rst),
		.int0 (int0),
		.int1 (int1),
		.din  (din),
		.addr (addr),
		.dout (dout),
		.rdn  (rdn),
		.wrn  (wrn)
	);

	// Word-wide memory answering in the same cycle
	assign din = mem[addr[8:1]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			value = {value[14:0], fb};
		end
		return value;
	endfunction

	function automatic wordT encode(input logic [3:0] grp, input logic [3:0] op,
			input regIdxT dst, input regIdxT src);
		return {grp, op, dst, src};
	endfunction

	// Body only touches r0 to r11
	function automatic regIdxT randReg();
		return regIdxT'(randBits(4) % 16'd12);
	endfunction

	function automatic wordT aluModel(input logic [1:0] op, input wordT a, input wordT b);
		case (op)
			opAdd[1:0]: return a + b;
			opSub[1:0]: return a - b;
			opAnd[1:0]: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	task automatic emit(input wordT value);
		mem[wp] = value;
		wp++;
	endtask

	task automatic buildProgram();
		logic [2:0] sel;
		int count;
		for (int i = 0; i < 256; i++) begin
			mem[i] = '0;
		end
		wp = 0;
		emit(encode(groupLoadStore, opLdi, 4'd15, 4'd0));
		emit(mainAddr);
		// Vector 0 slot doubles as the jump out of the reset path
		emit(encode(groupJump, opJmp, 4'd15, 4'd0));
		emit('0);
		emit(encode(groupJump, opJmp, 4'd14, 4'd0));
		wp = 8;
		emit(encode(groupLoadStore, opLdi, 4'd15, 4'd0));
		emit(handler0Addr);
		emit(encode(groupLoadStore, opLdi, 4'd14, 4'd0));
		emit(handler1Addr);
		emit(encode(groupLoadStore, opLdi, 4'd13, 4'd0));
		emit(checkpointAddr);
		emit(encode(groupLoadStore, opLdi, 4'd12, 4'd0));
		emit(bodyAddr);
		for (int r = 0; r < 12; r++) begin
			emit(encode(groupLoadStore, opLdi, regIdxT'(r), 4'd0));
			emit(randBits(16));
		end
		count = 0;
		while (wp < 246) begin
			count++;
			if (count % 6 == 0) begin
				emit(encode(groupLoadStore, opSt, 4'd13, randReg()));
			end else begin
				sel = 3'(randBits(3));
				case (sel)
					3'd4: emit(encode(groupLoadStore, opSt, randReg(), randReg()));
					3'd5: emit(encode(groupSystem, opEi, 4'd0, 4'd0));
					3'd6: emit(encode(groupSystem, opDi, 4'd0, 4'd0));
					default: emit(encode(groupAlu, {2'b00, sel[1:0]}, randReg(), randReg()));
				endcase
			end
		end
		emit(encode(groupJump, opJmp, 4'd12, 4'd0));
		// Handlers leave their own address as a marker
		wp = 248;
		emit(encode(groupLoadStore, opSt, 4'd15, 4'd15));
		emit(encode(groupSystem, opReti, 4'd0, 4'd0));
		wp = 252;
		emit(encode(groupLoadStore, opSt, 4'd14, 4'd14));
		emit(encode(groupSystem, opReti, 4'd0, 4'd0));
	endtask

	task automatic checkAddr(input string name, input addrT expected, input addrT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic checkStrobe(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic commitModel();
		addrT nextPc;
		addrT immAddr;
		logic isReti;
		logic take;
		immAddr = modelPc + 16'd2;
		nextPc = modelPc + 16'd2;
		isReti = (irGroup == groupSystem) && (irOp == opReti);
		if (irGroup == groupLoadStore && irOp == opLdi) begin
			nextPc = modelPc + 16'd4;
			regs[irDst] = mem[immAddr[8:1]];
		end else if (irGroup == groupAlu && irOp[3:2] == 2'b00) begin
			regs[irDst] = aluModel(irOp[1:0], regs[irDst], regs[irSrc]);
		end else if (irGroup == groupJump && irOp == opJmp) begin
			nextPc = regs[irDst];
		end else if (isReti) begin
			nextPc = modelRet;
		end
		// Enable and in-service as they stood before this commit
		take = !modelInSvc && (seen0[1] || (seen1[1] && modelEn));
		if (take) begin
			modelRet = nextPc;
			modelInSvc = 1'b1;
			if (seen0[1]) begin
				modelPc = vectorInt0;
				taken0++;
			end else begin
				modelPc = vectorInt1;
				taken1++;
			end
		end else begin
			modelPc = nextPc;
			if (isReti) begin
				modelInSvc = 1'b0;
			end
		end
		if (irGroup == groupSystem && irOp == opEi) begin
			modelEn = 1'b1;
		end else if (irGroup == groupSystem && irOp == opDi) begin
			modelEn = 1'b0;
		end
	endtask

	task automatic checkCycle(input int cycle);
		phaseT ph;
		logic isLdi;
		logic isSt;
		logic expRdn;
		logic expWrn;
		ph = phaseT'(cycle[1:0]);
		isLdi = (irGroup == groupLoadStore) && (irOp == opLdi);
		isSt = (irGroup == groupLoadStore) && (irOp == opSt);
		expRdn = 1'b1;
		expWrn = 1'b1;
		case (ph)
			phaseFetch: begin
				// First fetch after reset reads with rdn still high
				expRdn = (cycle == 0);
				checkAddr("fetch address", modelPc, addr);
				// A held line is released once the DUT fetches its vector
				if (int0 && addr === vectorInt0) begin
					ack0 = 1'b1;
				end
				if (int1 && addr === vectorInt1) begin
					ack1 = 1'b1;
				end
				{irGroup, irOp, irDst, irSrc} = mem[modelPc[8:1]];
			end
			phaseExecute: begin
				expRdn = !isLdi;
				expWrn = !isSt;
				if (isLdi) begin
					checkAddr("ldi immediate address", modelPc + 16'd2, addr);
				end
				if (isSt) begin
					checkAddr("store address", regs[irDst], addr);
					checkWord("store data", regs[irSrc], dout);
				end
			end
			phaseCommit: begin
				commitModel();
			end
			default: begin
				expRdn = 1'b1;
			end
		endcase
		checkStrobe($sformatf("%s rdn", ph.name()), expRdn, rdn);
		checkStrobe($sformatf("%s wrn", ph.name()), expWrn, wrn);
		// Lines reach the controller through two flops
		seen0 = {seen0[0], int0};
		seen1 = {seen1[0], int1};
	endtask

	// Lines are held until the DUT fetches their vector
	task automatic driveInterrupts(input int cycle);
		if (ack0) begin
			int0 = 1'b0;
			ack0 = 1'b0;
			hold0 = 0;
		end else if (int0) begin
			hold0++;
			if (hold0 > holdLimit) begin
				errors++;
				$display("INT0 was held for %0d cycles and never taken", hold0);
				int0 = 1'b0;
				hold0 = 0;
			end
		end else if (cycle > 100 && randBits(5) == 16'd0) begin
			int0 = 1'b1;
		end
		if (ack1) begin
			int1 = 1'b0;
			ack1 = 1'b0;
			hold1 = 0;
		end else if (int1) begin
			hold1++;
			// Masked line gives up quietly
			if (hold1 > holdLimit) begin
				int1 = 1'b0;
				hold1 = 0;
			end
		end else if (cycle > 100 && randBits(5) == 16'd0) begin
			int1 = 1'b1;
		end
	endtask

	initial begin
		rst = 1'b1;
		int0 = 1'b0;
		int1 = 1'b0;
		lfsr = 16'd27290;
		errors = 0;
		checks = 0;
		taken0 = 0;
		taken1 = 0;
		hold0 = 0;
		hold1 = 0;
		ack0 = 1'b0;
		ack1 = 1'b0;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		modelPc = resetAddr;
		modelRet = resetAddr;
		modelEn = 1'b0;
		modelInSvc = 1'b0;
		seen0 = '0;
		seen1 = '0;
		{irGroup, irOp, irDst, irSrc} = '0;
		buildProgram();
		repeat (5) @(posedge clk);
		#2 rst = 1'b0;
		for (int cycle = 0; cycle < numCycles; cycle++) begin
			@(negedge clk);
			checkCycle(cycle);
			@(posedge clk);
			#2 driveInterrupts(cycle);
		end
		if (taken0 == 0 || taken1 == 0) begin
			errors++;
			$display("An interrupt line was never taken during the run");
		end
		$display("Checks: %0d, errors: %0d, INT0 taken: %0d, INT1 taken: %0d", checks, errors,
			taken0, taken1);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/core_checker.sv
`timescale 1ns/100ps

module core_checker
	import corePkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  rdn,
	input logic  wrn,
	input phaseT phase
);

	// Bus never reads and writes at once
	strobesExclusive: assert property (
		@(posedge clk) disable iff (rst) !(!rdn && !wrn)
	) else $error("rdn and wrn are both low");

	// Idle bus in reset and on the first cycle after it
	strobesIdleInReset: assert property (
		@(posedge clk) rst |=> (rdn && wrn)
	) else $error("Bus strobe active during or right after reset");

	// Fetch, decode, execute, commit in a fixed rotation
	phaseRotation: assert property (
		@(posedge clk) disable iff (rst) !rst |=> (phase == phaseT'($past(phase) + 2'd1))
	) else $error("Phase did not advance in order");

	// Stores only drive the bus in execute
	writeInExecute: assert property (
		@(posedge clk) disable iff (rst) !wrn |-> (phase == phaseExecute)
	) else $error("Write strobe outside the execute phase");

endmodule

bind core core_checker u_checker (
	.clk   (clk),
	.rst   (rst),
	.rdn   (rdn),
	.wrn   (wrn),
	.phase (phase)
);

// File: rtl/core.sv
`timescale 1ns/100ps

module core
	import corePkg::*;
#(
	parameter int numRegs = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic int0,
	input  logic int1,
	input  wordT din,
	output addrT addr,
	output wordT dout,
	output logic rdn,
	output logic wrn
);

	phaseT phase;
	regIdxT srcIdx;
	regIdxT dstIdx;
	logic [1:0] aluOp;
	logic isLdi;
	logic isSt;
	logic isAlu;
	logic isJmp;
	logic isEi;
	logic isDi;
	logic isReti;
	logic takeInt;
	logic vectorSel;
	wordT regDst;
	wordT regSrc;
	addrT pc;

	phaseSequencer u_phaseSequencer (
		.clk   (clk),
		.rst   (rst),
		.phase (phase)
	);

	instructionDecoder u_instructionDecoder (
		.clk    (clk),
		.rst    (rst),
		.phase  (phase),
		.din    (din),
		.srcIdx (srcIdx),
		.dstIdx (dstIdx),
		.aluOp  (aluOp),
		.isLdi  (isLdi),
		.isSt   (isSt),
		.isAlu  (isAlu),
		.isJmp  (isJmp),
		.isEi   (isEi),
		.isDi   (isDi),
		.isReti (isReti)
	);

	registerDatapath #(
		.numRegs (numRegs)
	) u_registerDatapath (
		.clk    (clk),
		.rst    (rst),
		.phase  (phase),
		.srcIdx (srcIdx),
		.dstIdx (dstIdx),
		.aluOp  (aluOp),
		.isLdi  (isLdi),
		.isAlu  (isAlu),
		.din    (din),
		.regDst (regDst),
		.regSrc (regSrc)
	);

	interruptController u_interruptController (
		.clk       (clk),
		.rst       (rst),
		.phase     (phase),
		.int0      (int0),
		.int1      (int1),
		.isEi      (isEi),
		.isDi      (isDi),
		.isReti    (isReti),
		.takeInt   (takeInt),
		.vectorSel (vectorSel)
	);

	programCounter u_programCounter (
		.clk       (clk),
		.rst       (rst),
		.phase     (phase),
		.isLdi     (isLdi),
		.isJmp     (isJmp),
		.isReti    (isReti),
		.takeInt   (takeInt),
		.vectorSel (vectorSel),
		.regDst    (regDst),
		.pc        (pc)
	);

	// Store uses the destination register as address
	always_comb begin
		if (phase == phaseExecute && isSt) begin
			addr = regDst;
		end else if (phase == phaseExecute && isLdi) begin
			addr = pc + addrT'(2);
		end else begin
			addr = pc;
		end
	end

	assign dout = regSrc;

	// Strobes are registered one phase ahead so they leave reset high;
	// the memory answers combinationally, so the first fetch still reads
	always_ff @(posedge clk) begin
		if (rst) begin
			rdn <= 1'b1;
			wrn <= 1'b1;
		end else begin
			case (phase)
				phaseCommit: begin
					rdn <= 1'b0;
				end
				phaseDecode: begin
					rdn <= !isLdi;
				end
				default: begin
					rdn <= 1'b1;
				end
			endcase
			wrn <= !(phase == phaseDecode && isSt);
		end
	end

endmodule

// File: rtl/programCounter.sv
`timescale 1ns/100ps

module programCounter
	import corePkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  phaseT phase,
	input  logic  isLdi,
	input  logic  isJmp,
	input  logic  isReti,
	input  logic  takeInt,
	input  logic  vectorSel,
	input  wordT  regDst,
	output addrT  pc
);

	addrT seqAddr;
	addrT nextAddr;
	addrT retAddr;
	addrT vectorAddr;

	// LDI carries its immediate in the following word
	assign seqAddr = pc + (isLdi ? addrT'(4) : addrT'(2));

	// Address fetched next when no interrupt intervenes
	always_comb begin
		if (isReti) begin
			nextAddr = retAddr;
		end else if (isJmp) begin
			nextAddr = regDst;
		end else begin
			nextAddr = seqAddr;
		end
	end

	assign vectorAddr = vectorSel ? vectorInt1 : vectorInt0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetAddr;
			retAddr <= resetAddr;
		end else if (phase == phaseCommit) begin
			if (takeInt) begin
				pc <= vectorAddr;
				retAddr <= nextAddr;
			end else begin
				pc <= nextAddr;
			end
		end
	end

endmodule

// File: rtl/interruptController.sv
`timescale 1ns/100ps

module interruptController
	import corePkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  phaseT phase,
	input  logic  int0,
	input  logic  int1,
	input  logic  isEi,
	input  logic  isDi,
	input  logic  isReti,
	output logic  takeInt,
	output logic  vectorSel
);

	logic [1:0] int0Sync;
	logic [1:0] int1Sync;
	logic int1En;
	logic inService;
	logic pend0;
	logic pend1;

	// Lines are asynchronous levels
	always_ff @(posedge clk) begin
		if (rst) begin
			int0Sync <= '0;
			int1Sync <= '0;
		end else begin
			int0Sync <= {int0Sync[0], int0};
			int1Sync <= {int1Sync[0], int1};
		end
	end

	// INT0 cannot be masked
	assign pend0 = int0Sync[1];
	assign pend1 = int1Sync[1] & int1En;

	// Enable and in-service are sampled before this commit's own update
	assign takeInt = (phase == phaseCommit) && !inService && (pend0 || pend1);

	// High selects INT1, INT0 has priority
	assign vectorSel = !pend0;

	always_ff @(posedge clk) begin
		if (rst) begin
			int1En <= 1'b0;
			inService <= 1'b0;
		end else if (phase == phaseCommit) begin
			if (isEi) begin
				int1En <= 1'b1;
			end else if (isDi) begin
				int1En <= 1'b0;
			end
			if (takeInt) begin
				inService <= 1'b1;
			end else if (isReti) begin
				inService <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/registerDatapath.sv
`timescale 1ns/100ps

module registerDatapath
	import corePkg::*;
#(
	parameter int numRegs = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  phaseT      phase,
	input  regIdxT     srcIdx,
	input  regIdxT     dstIdx,
	input  logic [1:0] aluOp,
	input  logic       isLdi,
	input  logic       isAlu,
	input  wordT       din,
	output wordT       regDst,
	output wordT       regSrc
);

	// With fewer registers the upper index bits drop out
	localparam int idxBits = $clog2(numRegs);

	wordT regFile [numRegs];
	wordT immediate;
	wordT aluResult;
	logic [idxBits-1:0] dstSel;
	logic [idxBits-1:0] srcSel;

	assign dstSel = dstIdx[idxBits-1:0];
	assign srcSel = srcIdx[idxBits-1:0];

	// Jump target and store address come from the destination field
	assign regDst = regFile[dstSel];
	assign regSrc = regFile[srcSel];

	always_comb begin
		case (aluOp)
			opAdd[1:0]: begin
				aluResult = regDst + regSrc;
			end
			opSub[1:0]: begin
				aluResult = regDst - regSrc;
			end
			opAnd[1:0]: begin
				aluResult = regDst & regSrc;
			end
			default: begin
				aluResult = regDst ^ regSrc;
			end
		endcase
	end

	// Second word of LDI is on the bus during execute
	always_ff @(posedge clk) begin
		if (phase == phaseExecute && isLdi) begin
			immediate <= din;
		end
	end

	// Write-back at commit only
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regFile[i] <= '0;
			end
		end else if (phase == phaseCommit) begin
			if (isLdi) begin
				regFile[dstSel] <= immediate;
			end else if (isAlu) begin
				regFile[dstSel] <= aluResult;
			end
		end
	end

endmodule

// File: rtl/instructionDecoder.sv
`timescale 1ns/100ps

module instructionDecoder
	import corePkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  phaseT      phase,
	input  wordT       din,
	output regIdxT     srcIdx,
	output regIdxT     dstIdx,
	output logic [1:0] aluOp,
	output logic       isLdi,
	output logic       isSt,
	output logic       isAlu,
	output logic       isJmp,
	output logic       isEi,
	output logic       isDi,
	output logic       isReti
);

	wordT instr;
	logic [3:0] group;
	logic [3:0] op;

	// Instruction register, cleared so reset decodes as a no-op
	always_ff @(posedge clk) begin
		if (rst) begin
			instr <= '0;
		end else if (phase == phaseFetch) begin
			instr <= din;
		end
	end

	assign group = instr[groupHi:groupLo];
	assign op = instr[opHi:opLo];
	assign dstIdx = instr[dstHi:dstLo];
	assign srcIdx = instr[srcHi:srcLo];
	assign aluOp = op[1:0];

	always_comb begin
		isLdi = 1'b0;
		isSt = 1'b0;
		isAlu = 1'b0;
		isJmp = 1'b0;
		isEi = 1'b0;
		isDi = 1'b0;
		isReti = 1'b0;
		case (group)
			groupLoadStore: begin
				isLdi = (op == opLdi);
				isSt = (op == opSt);
			end
			groupJump: begin
				isJmp = (op == opJmp);
			end
			groupAlu: begin
				// Only the four ALU encodings are valid
				isAlu = (op[3:2] == 2'b00);
			end
			groupSystem: begin
				isEi = (op == opEi);
				isDi = (op == opDi);
				isReti = (op == opReti);
			end
			default: begin
				isLdi = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/phaseSequencer.sv
`timescale 1ns/100ps

module phaseSequencer
	import corePkg::*;
(
	input  logic  clk,
	input  logic  rst,
	output phaseT phase
);

	phaseT nextPhase;

	// Fixed rotation, no stalls
	always_comb begin
		case (phase)
			phaseFetch: begin
				nextPhase = phaseDecode;
			end
			phaseDecode: begin
				nextPhase = phaseExecute;
			end
			phaseExecute: begin
				nextPhase = phaseCommit;
			end
			default: begin
				nextPhase = phaseFetch;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= phaseFetch;
		end else begin
			phase <= nextPhase;
		end
	end

endmodule

// File: rtl/corePkg.sv
package corePkg;

	// Data and instruction word
	typedef logic [15:0] wordT;

	// Byte address, instructions sit two bytes apart
	typedef logic [15:0] addrT;

	typedef logic [3:0] regIdxT;

	typedef enum logic [1:0] {
		phaseFetch,
		phaseDecode,
		phaseExecute,
		phaseCommit
	} phaseT;

	// Instruction field positions
	localparam int groupHi = 15;
	localparam int groupLo = 12;
	localparam int opHi = 11;
	localparam int opLo = 8;
	localparam int dstHi = 7;
	localparam int dstLo = 4;
	localparam int srcHi = 3;
	localparam int srcLo = 0;

	// Groups
	localparam logic [3:0] groupSystem = 4'h1;
	localparam logic [3:0] groupLoadStore = 4'h2;
	localparam logic [3:0] groupJump = 4'h3;
	localparam logic [3:0] groupAlu = 4'h4;

	// Load/store operations
	localparam logic [3:0] opLdi = 4'h0;
	localparam logic [3:0] opSt = 4'h1;

	// ALU operations, low two bits form the ALU select
	localparam logic [3:0] opAdd = 4'h0;
	localparam logic [3:0] opSub = 4'h1;
	localparam logic [3:0] opAnd = 4'h2;
	localparam logic [3:0] opXor = 4'h3;

	// Jump and system operations
	localparam logic [3:0] opJmp = 4'h0;
	localparam logic [3:0] opEi = 4'h1;
	localparam logic [3:0] opDi = 4'h2;
	localparam logic [3:0] opReti = 4'h3;

	localparam addrT resetAddr = 16'h0000;
	localparam addrT vectorInt0 = 16'h0004;
	localparam addrT vectorInt1 = 16'h0008;

endpackage
